//--- logic/hough_pkg.sv
/* Shared sizes, trig tables and vector types of the Hough lane finder.
   Every RTL file refers to these through hough_pkg:: scoped names */
package hough_pkg;

    // Vector types for the quantities that travel between blocks
    typedef logic [7:0] pixel_address_t;
    typedef logic [7:0] pixel_t;
    typedef logic [3:0] coordinate_t;
    typedef logic [3:0] theta_t;
    typedef logic [5:0] rho_t;
    typedef logic [9:0] vote_t;
    typedef logic [1:0] config_address_t;

    // The pixel address is row-major so it is simply {y, x}
    localparam int image_width = 16;
    localparam int image_height = 16;
    localparam int pixel_count = image_width * image_height;

    // Thetas are spaced 180/16 degrees apart starting at zero
    localparam int theta_count = 16;
    localparam int trig_frac_bits = 8;

    // Cosine and sine scaled by 2^trig_frac_bits and rounded to the nearest integer
    localparam logic signed [15:0] cos_table [0:theta_count-1] = '{
        16'sd256, 16'sd251, 16'sd237, 16'sd213,
        16'sd181, 16'sd142, 16'sd98, 16'sd50,
        16'sd0, -16'sd50, -16'sd98, -16'sd142,
        -16'sd181, -16'sd213, -16'sd237, -16'sd251
    };
    localparam logic signed [15:0] sin_table [0:theta_count-1] = '{
        16'sd0, 16'sd50, 16'sd98, 16'sd142,
        16'sd181, 16'sd213, 16'sd237, 16'sd251,
        16'sd256, 16'sd251, 16'sd237, 16'sd213,
        16'sd181, 16'sd142, 16'sd98, 16'sd50
    };

    // The most negative rho is about -15 so this bias keeps every row index positive
    localparam int rho_offset = 23;
    localparam int rho_range = 48;

    // Thetas below this limit vote for the left lane, the rest for the right lane
    localparam int left_theta_limit = 8;

    // Register map of the configuration block
    localparam config_address_t control_address = 2'd0;
    localparam config_address_t mask_threshold_address = 2'd1;
    localparam config_address_t min_votes_address = 2'd2;

    localparam pixel_t mask_threshold_reset = 8'h0F;
    localparam vote_t min_votes_reset = 10'd4;

endpackage

//--- logic/image_bram.sv
/* Single-clock pixel memory with one write port and a registered read port.
   Instantiated once for the edge map and once for the region mask */
module image_bram (
    input  logic                      clock,
    input  logic                      write,
    input  hough_pkg::pixel_address_t write_address,
    input  hough_pkg::pixel_t         write_data,
    input  hough_pkg::pixel_address_t read_address,
    output hough_pkg::pixel_t         read_data
);

    // One byte per pixel in row-major order
    hough_pkg::pixel_t memory [0:hough_pkg::pixel_count-1];

    // A read in the same cycle as a write to that address returns the old byte
    always_ff @(posedge clock) begin
        if (write) begin
            memory[write_address] <= write_data;
        end
        read_data <= memory[read_address];
    end

endmodule

//--- logic/hough_config.sv
/* Register block with the mask threshold, the minimum lane votes and the busy flag.
   A write of bit 0 to the control register starts a run when the block is idle */
module hough_config (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       config_write,
    input  hough_pkg::config_address_t config_address,
    input  hough_pkg::pixel_t          config_data,
    output hough_pkg::pixel_t          config_read_data,
    input  logic                       done,
    output logic                       run_start,
    output hough_pkg::pixel_t          mask_threshold,
    output hough_pkg::vote_t           min_votes
);

    // High from the cycle after an accepted start until the selector reports done
    logic busy;

    // A start request during a run is dropped here and never reaches the accumulator
    assign run_start = config_write
        && (config_address == hough_pkg::control_address)
        && config_data[0]
        && !busy;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            mask_threshold <= hough_pkg::mask_threshold_reset;
            min_votes <= hough_pkg::min_votes_reset;
        end else begin
            if (run_start) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end

            // Settings may be rewritten at any time and are read directly during the run
            if (config_write && (config_address == hough_pkg::mask_threshold_address)) begin
                mask_threshold <= config_data;
            end
            if (config_write && (config_address == hough_pkg::min_votes_address)) begin
                min_votes <= hough_pkg::vote_t'(config_data);
            end
        end
    end

    // The read is combinational and the control address shows busy in bit 0
    always_comb begin
        case (config_address)
            hough_pkg::control_address: config_read_data = {7'b0, busy};
            hough_pkg::mask_threshold_address: config_read_data = mask_threshold;
            hough_pkg::min_votes_address: config_read_data = min_votes[7:0];
            default: config_read_data = '0;
        endcase
    end

endmodule

//--- logic/hough_accumulator.sv
/* Walks the edge map and mask, and votes each qualifying pixel into the rho/theta array.
   The vote array is read back one cell at a time through the cell port */
module hough_accumulator (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      run_start,
    input  hough_pkg::pixel_t         mask_threshold,
    output hough_pkg::pixel_address_t edge_read_address,
    output hough_pkg::pixel_address_t mask_read_address,
    input  hough_pkg::pixel_t         edge_read_data,
    input  hough_pkg::pixel_t         mask_read_data,
    output logic                      accumulate_done,
    input  hough_pkg::rho_t           cell_rho,
    input  hough_pkg::theta_t         cell_theta,
    output hough_pkg::vote_t          cell_votes
);

    typedef enum logic [1:0] {
        idle,
        examine,
        theta_loop
    } state_t;

    state_t state;

    // Coordinates of the pixel whose memory data is (or was) on the read ports
    hough_pkg::coordinate_t x;
    hough_pkg::coordinate_t y;
    hough_pkg::theta_t theta;

    hough_pkg::vote_t votes [0:hough_pkg::rho_range-1][0:hough_pkg::theta_count-1];

    logic pixel_votes;
    logic last_theta;
    logic last_pixel;
    logic advance;
    hough_pkg::pixel_address_t next_address;

    logic signed [15:0] x_term;
    logic signed [15:0] y_term;
    logic signed [15:0] rho_sum;
    hough_pkg::rho_t rho_row;

    // A pixel votes when it is an edge and the mask byte reaches the threshold
    assign pixel_votes = (edge_read_data != '0) && (mask_read_data >= mask_threshold);
    assign last_theta = theta == hough_pkg::theta_t'(hough_pkg::theta_count - 1);
    assign last_pixel = (x == hough_pkg::coordinate_t'(hough_pkg::image_width - 1))
        && (y == hough_pkg::coordinate_t'(hough_pkg::image_height - 1));

    // The pixel is finished either right away or after its last theta
    assign advance = ((state == examine) && !pixel_votes)
        || ((state == theta_loop) && last_theta);

    // Row-major order makes the address {y, x}, wrapping to zero after the last pixel
    assign next_address = {y, x} + 1'b1;

    // Prefetch so the next pixel's bytes arrive in the cycle it is examined.
    // In idle x and y sit at zero, so the first address goes out with run_start
    assign edge_read_address = advance ? next_address : {y, x};
    assign mask_read_address = edge_read_address;

    // Both products fit comfortably in 16 signed bits for 4-bit coordinates
    assign x_term = $signed({12'b0, x}) * hough_pkg::cos_table[theta];
    assign y_term = $signed({12'b0, y}) * hough_pkg::sin_table[theta];
    assign rho_sum = x_term + y_term;

    // Arithmetic shift floors toward minus infinity before the bias is added
    assign rho_row = hough_pkg::rho_t'((rho_sum >>> hough_pkg::trig_frac_bits)
        + hough_pkg::rho_offset);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
            x <= '0;
            y <= '0;
            theta <= '0;
            accumulate_done <= 1'b0;
        end else begin
            accumulate_done <= advance && last_pixel;
            case (state)
                idle: begin
                    if (run_start) begin
                        state <= examine;
                    end
                end
                examine: begin
                    if (pixel_votes) begin
                        state <= theta_loop;
                    end else if (last_pixel) begin
                        state <= idle;
                    end
                end
                theta_loop: begin
                    // Theta wraps back to zero after the last one
                    theta <= theta + 1'b1;
                    if (last_theta) begin
                        state <= last_pixel ? idle : examine;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
            if (advance) begin
                {y, x} <= next_address;
            end
        end
    end

    // The array is cleared at the start of a run and takes one vote per cycle
    always_ff @(posedge clock) begin
        if (run_start) begin
            for (int r = 0; r < hough_pkg::rho_range; r++) begin
                for (int t = 0; t < hough_pkg::theta_count; t++) begin
                    votes[r][t] <= '0;
                end
            end
        end else if (state == theta_loop) begin
            votes[rho_row][theta] <= votes[rho_row][theta] + 1'b1;
        end
    end

    assign cell_votes = votes[cell_rho][cell_theta];

endmodule

//--- logic/lane_select.sv
/* Scans the vote array one cell per cycle and keeps the strongest left and right line.
   Starts on accumulate_done and pulses done 769 cycles later with the results */
module lane_select (
    input  logic              clock,
    input  logic              reset,
    input  logic              accumulate_done,
    input  hough_pkg::vote_t  min_votes,
    output hough_pkg::rho_t   cell_rho,
    output hough_pkg::theta_t cell_theta,
    input  hough_pkg::vote_t  cell_votes,
    output logic              done,
    output hough_pkg::rho_t   left_rho,
    output hough_pkg::rho_t   right_rho,
    output hough_pkg::theta_t left_theta,
    output hough_pkg::theta_t right_theta,
    output hough_pkg::vote_t  left_votes,
    output hough_pkg::vote_t  right_votes,
    output logic              left_valid,
    output logic              right_valid
);

    logic scanning;
    logic last_cell;
    logic take_left;
    logic take_right;

    // Running maximum of each lane side
    hough_pkg::vote_t left_best_votes;
    hough_pkg::vote_t right_best_votes;
    hough_pkg::rho_t left_best_rho;
    hough_pkg::rho_t right_best_rho;
    hough_pkg::theta_t left_best_theta;
    hough_pkg::theta_t right_best_theta;

    // Maxima that include the cell on the port for use at the last cell
    hough_pkg::vote_t left_final_votes;
    hough_pkg::vote_t right_final_votes;

    assign last_cell = scanning
        && (cell_theta == hough_pkg::theta_t'(hough_pkg::theta_count - 1))
        && (cell_rho == hough_pkg::rho_t'(hough_pkg::rho_range - 1));

    // Only a strictly larger count replaces the maximum, so the earliest cell wins a tie
    assign take_left = scanning
        && (cell_theta < hough_pkg::theta_t'(hough_pkg::left_theta_limit))
        && (cell_votes > left_best_votes);
    assign take_right = scanning
        && (cell_theta >= hough_pkg::theta_t'(hough_pkg::left_theta_limit))
        && (cell_votes > right_best_votes);

    assign left_final_votes = take_left ? cell_votes : left_best_votes;
    assign right_final_votes = take_right ? cell_votes : right_best_votes;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            scanning <= 1'b0;
            cell_rho <= '0;
            cell_theta <= '0;
            done <= 1'b0;
            left_best_votes <= '0;
            right_best_votes <= '0;
            left_best_rho <= '0;
            right_best_rho <= '0;
            left_best_theta <= '0;
            right_best_theta <= '0;
            left_rho <= '0;
            right_rho <= '0;
            left_theta <= '0;
            right_theta <= '0;
            left_votes <= '0;
            right_votes <= '0;
            left_valid <= 1'b0;
            right_valid <= 1'b0;
        end else begin
            done <= last_cell;
            if (accumulate_done) begin
                // A fresh scan begins at cell (0, 0) with both maxima at zero
                scanning <= 1'b1;
                cell_rho <= '0;
                cell_theta <= '0;
                left_best_votes <= '0;
                right_best_votes <= '0;
                left_best_rho <= '0;
                right_best_rho <= '0;
                left_best_theta <= '0;
                right_best_theta <= '0;
            end else if (scanning) begin
                // Rho is the inner loop and theta the outer one
                if (cell_rho == hough_pkg::rho_t'(hough_pkg::rho_range - 1)) begin
                    cell_rho <= '0;
                    cell_theta <= cell_theta + 1'b1;
                end else begin
                    cell_rho <= cell_rho + 1'b1;
                end
                if (take_left) begin
                    left_best_votes <= cell_votes;
                    left_best_rho <= cell_rho;
                    left_best_theta <= cell_theta;
                end
                if (take_right) begin
                    right_best_votes <= cell_votes;
                    right_best_rho <= cell_rho;
                    right_best_theta <= cell_theta;
                end
                if (last_cell) begin
                    scanning <= 1'b0;
                end
            end

            // Results change together with the done pulse and then hold
            if (last_cell) begin
                left_votes <= left_final_votes;
                left_rho <= take_left ? cell_rho : left_best_rho;
                left_theta <= take_left ? cell_theta : left_best_theta;
                left_valid <= left_final_votes >= min_votes;
                right_votes <= right_final_votes;
                right_rho <= take_right ? cell_rho : right_best_rho;
                right_theta <= take_right ? cell_theta : right_best_theta;
                right_valid <= right_final_votes >= min_votes;
            end
        end
    end

endmodule

//--- logic/lane_hough_top.sv
/* Top level of the Hough lane finder with the two image memories and the register block.
   The outside loads both images, sets the registers and starts a run through them */
module lane_hough_top (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       edge_write,
    input  logic                       mask_write,
    input  hough_pkg::pixel_address_t  pixel_address,
    input  hough_pkg::pixel_t          pixel_data,
    input  logic                       config_write,
    input  hough_pkg::config_address_t config_address,
    input  hough_pkg::pixel_t          config_data,
    output hough_pkg::pixel_t          config_read_data,
    output logic                       done,
    output hough_pkg::rho_t            left_rho,
    output hough_pkg::theta_t          left_theta,
    output hough_pkg::vote_t           left_votes,
    output logic                       left_valid,
    output hough_pkg::rho_t            right_rho,
    output hough_pkg::theta_t          right_theta,
    output hough_pkg::vote_t           right_votes,
    output logic                       right_valid
);

    logic run_start;
    logic accumulate_done;
    hough_pkg::pixel_t mask_threshold;
    hough_pkg::vote_t min_votes;
    hough_pkg::pixel_address_t edge_read_address;
    hough_pkg::pixel_address_t mask_read_address;
    hough_pkg::pixel_t edge_read_data;
    hough_pkg::pixel_t mask_read_data;
    hough_pkg::rho_t cell_rho;
    hough_pkg::theta_t cell_theta;
    hough_pkg::vote_t cell_votes;

    // Both memories share the outside write address and data
    image_bram edge_memory (
        .clock         (clock),
        .write         (edge_write),
        .write_address (pixel_address),
        .write_data    (pixel_data),
        .read_address  (edge_read_address),
        .read_data     (edge_read_data)
    );

    image_bram mask_memory (
        .clock         (clock),
        .write         (mask_write),
        .write_address (pixel_address),
        .write_data    (pixel_data),
        .read_address  (mask_read_address),
        .read_data     (mask_read_data)
    );

    hough_config config_block (
        .clock            (clock),
        .reset            (reset),
        .config_write     (config_write),
        .config_address   (config_address),
        .config_data      (config_data),
        .config_read_data (config_read_data),
        .done             (done),
        .run_start        (run_start),
        .mask_threshold   (mask_threshold),
        .min_votes        (min_votes)
    );

    hough_accumulator accumulator (
        .clock             (clock),
        .reset             (reset),
        .run_start         (run_start),
        .mask_threshold    (mask_threshold),
        .edge_read_address (edge_read_address),
        .mask_read_address (mask_read_address),
        .edge_read_data    (edge_read_data),
        .mask_read_data    (mask_read_data),
        .accumulate_done   (accumulate_done),
        .cell_rho          (cell_rho),
        .cell_theta        (cell_theta),
        .cell_votes        (cell_votes)
    );

    lane_select selector (
        .clock           (clock),
        .reset           (reset),
        .accumulate_done (accumulate_done),
        .min_votes       (min_votes),
        .cell_rho        (cell_rho),
        .cell_theta      (cell_theta),
        .cell_votes      (cell_votes),
        .done            (done),
        .left_rho        (left_rho),
        .right_rho       (right_rho),
        .left_theta      (left_theta),
        .right_theta     (right_theta),
        .left_votes      (left_votes),
        .right_votes     (right_votes),
        .left_valid      (left_valid),
        .right_valid     (right_valid)
    );

endmodule

//--- verification/clock_gen.sv
/* Free-running 8 ns testbench clock and an active-high reset held for the first 8 cycles */
module clock_gen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
    end

    always #4 clock = ~clock;

endmodule

//--- verification/lane_hough_chk.sv
/* Protocol assertions on the lane finder top level.
   Attached to lane_hough_top with bind from the testbench */
module lane_hough_chk (
    input logic clock,
    input logic reset,
    input logic done,
    input logic accumulate_done,
    input logic run_start
);
    timeunit 1ns;
    timeprecision 100ps;

    // One cycle per array cell and one more for the result registers
    localparam int scan_cycles = hough_pkg::rho_range * hough_pkg::theta_count + 1;

    // Number of failed assertions over the whole run
    int assertion_failures = 0;

    // A run is in flight from an accepted start until the selector reports done
    logic run_active;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            run_active <= 1'b0;
        end else if (run_start) begin
            run_active <= 1'b1;
        end else if (done) begin
            run_active <= 1'b0;
        end
    end

    done_single: assert property (@(posedge clock) disable iff (reset) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            assertion_failures++;
        end

    accumulate_single: assert property (@(posedge clock) disable iff (reset)
        accumulate_done |=> !accumulate_done)
        else begin
            $error("accumulate_done stayed high for more than one cycle");
            assertion_failures++;
        end

    // The register block must refuse any start while a run is in flight
    start_when_idle: assert property (@(posedge clock) disable iff (reset)
        run_start |-> !run_active)
        else begin
            $error("run_start issued while a run was in flight");
            assertion_failures++;
        end

    scan_latency: assert property (@(posedge clock) disable iff (reset)
        done |-> $past(accumulate_done, scan_cycles))
        else begin
            $error("done did not follow accumulate_done by the scan latency");
            assertion_failures++;
        end

endmodule

//--- verification/lane_hough_tb.sv
/* Table-driven testbench of the Hough lane finder with a reference vote model.
   Each table entry loads both images, runs the DUT and compares every result port */
module lane_hough_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int test_total = 7;
    localparam int kind_empty = 0;
    localparam int kind_lines = 1;
    localparam int kind_masked = 2;
    localparam int kind_random = 3;
    localparam int scan_cycles = hough_pkg::rho_range * hough_pkg::theta_count + 1;
    // Worst case run has every pixel voting on every theta, followed by the full scan
    localparam int run_cycles = hough_pkg::pixel_count * (hough_pkg::theta_count + 1)
        + scan_cycles;
    // Image load, register traffic and the quiet window after done
    localparam int load_cycles = 2 * hough_pkg::pixel_count + scan_cycles + 64;
    localparam int watchdog_ns = 2 * (test_total + 1) * (run_cycles + load_cycles) * 8;

    logic clock;
    logic reset;
    logic edge_write;
    logic mask_write;
    hough_pkg::pixel_address_t pixel_address;
    hough_pkg::pixel_t pixel_data;
    logic config_write;
    hough_pkg::config_address_t config_address;
    hough_pkg::pixel_t config_data;
    hough_pkg::pixel_t config_read_data;
    logic done;
    hough_pkg::rho_t left_rho;
    hough_pkg::theta_t left_theta;
    hough_pkg::vote_t left_votes;
    logic left_valid;
    hough_pkg::rho_t right_rho;
    hough_pkg::theta_t right_theta;
    hough_pkg::vote_t right_votes;
    logic right_valid;

    // Test table with the name, image pattern, mask threshold and minimum lane votes
    string test_name [test_total] = '{"empty", "line_pair", "masked_low", "masked_high",
        "high_min_votes", "random_a", "random_b"};
    int test_kind [test_total] = '{kind_empty, kind_lines, kind_masked, kind_masked,
        kind_lines, kind_random, kind_random};
    int test_threshold [test_total] = '{8'h0F, 8'h0F, 8'h0F, 8'h80, 8'h0F, 8'h40, 8'h10};
    int test_min_votes [test_total] = '{4, 4, 4, 4, 200, 4, 12};

    hough_pkg::pixel_t edge_image [hough_pkg::pixel_count];
    hough_pkg::pixel_t mask_image [hough_pkg::pixel_count];
    int model_votes [hough_pkg::rho_range][hough_pkg::theta_count];
    // Expected winners with index 0 for the left lane and index 1 for the right lane
    int best_votes [2];
    int best_rho [2];
    int best_theta [2];
    int best_valid [2];
    int seed = 32'hef17_8385;
    int error_count = 0;
    int failed_tests = 0;

    clock_gen clock_source (.clock(clock), .reset(reset));

    lane_hough_top UUT (.*);

    bind lane_hough_top lane_hough_chk protocol_checker (
        .clock           (clock),
        .reset           (reset),
        .done            (done),
        .accumulate_done (accumulate_done),
        .run_start       (run_start)
    );

    task automatic check_value(input string what, input int got, input int expected);
        if (got !== expected) begin
            $display("Fail at %0t ns: %0s is %0d, expected %0d", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("Test %0s: ok", name);
        end else begin
            $display("Test %0s: %0d errors", name, error_count - errors_before);
            failed_tests++;
        end
    endtask

    // Lines are the diagonal x == y and the anti-diagonal x + y == 15
    task automatic fill_images(input int kind);
        int x;
        int y;
        for (int a = 0; a < hough_pkg::pixel_count; a++) begin
            x = a % hough_pkg::image_width;
            y = a / hough_pkg::image_width;
            edge_image[a] = '0;
            mask_image[a] = hough_pkg::pixel_t'(8'hC0 | ((a >> 2) ^ (a & 8'h3F)));
            if ((kind == kind_lines || kind == kind_masked)
                    && (x == y || x + y == hough_pkg::image_width - 1)) begin
                edge_image[a] = hough_pkg::pixel_t'(a | 1);
            end
            if (kind == kind_masked) begin
                mask_image[a] = hough_pkg::pixel_t'(x * 16 + y);
            end
            if (kind == kind_random) begin
                edge_image[a] = (($random(seed) & 3) == 0) ? hough_pkg::pixel_t'(a | 1) : '0;
                mask_image[a] = hough_pkg::pixel_t'($random(seed));
            end
        end
    endtask

    task automatic build_model(input int threshold, input int min_votes);
        int x;
        int y;
        int rho;
        int side;
        for (int r = 0; r < hough_pkg::rho_range; r++) begin
            for (int t = 0; t < hough_pkg::theta_count; t++) begin
                model_votes[r][t] = 0;
            end
        end
        for (int a = 0; a < hough_pkg::pixel_count; a++) begin
            x = a % hough_pkg::image_width;
            y = a / hough_pkg::image_width;
            if (edge_image[a] != 0 && int'(mask_image[a]) >= threshold) begin
                for (int t = 0; t < hough_pkg::theta_count; t++) begin
                    rho = ((x * int'(hough_pkg::cos_table[t]) + y * int'(hough_pkg::sin_table[t]))
                        >>> hough_pkg::trig_frac_bits) + hough_pkg::rho_offset;
                    model_votes[rho][t]++;
                end
            end
        end
        for (int s = 0; s < 2; s++) begin
            best_votes[s] = 0;
            best_rho[s] = 0;
            best_theta[s] = 0;
        end
        // Theta outer, rho inner, and only a strictly larger count takes over
        for (int t = 0; t < hough_pkg::theta_count; t++) begin
            for (int r = 0; r < hough_pkg::rho_range; r++) begin
                side = (t < hough_pkg::left_theta_limit) ? 0 : 1;
                if (model_votes[r][t] > best_votes[side]) begin
                    best_votes[side] = model_votes[r][t];
                    best_rho[side] = r;
                    best_theta[side] = t;
                end
            end
        end
        for (int s = 0; s < 2; s++) begin
            best_valid[s] = (best_votes[s] >= min_votes) ? 1 : 0;
        end
    endtask

    // Each pixel takes two cycles since both memories share the address and data
    task automatic load_images();
        for (int a = 0; a < hough_pkg::pixel_count; a++) begin
            @(posedge clock);
            edge_write <= 1'b1;
            mask_write <= 1'b0;
            pixel_address <= hough_pkg::pixel_address_t'(a);
            pixel_data <= edge_image[a];
            @(posedge clock);
            edge_write <= 1'b0;
            mask_write <= 1'b1;
            pixel_data <= mask_image[a];
        end
        @(posedge clock);
        mask_write <= 1'b0;
    endtask

    task automatic write_register(input hough_pkg::config_address_t address, input int data);
        @(posedge clock);
        config_write <= 1'b1;
        config_address <= address;
        config_data <= hough_pkg::pixel_t'(data);
        @(posedge clock);
        config_write <= 1'b0;
    endtask

    task automatic read_register(input hough_pkg::config_address_t address, output int value);
        @(posedge clock);
        config_address <= address;
        @(negedge clock);
        value = int'(config_read_data);
    endtask

    task automatic compare_results();
        check_value("left_rho", int'(left_rho), best_rho[0]);
        check_value("left_theta", int'(left_theta), best_theta[0]);
        check_value("left_votes", int'(left_votes), best_votes[0]);
        check_value("left_valid", int'(left_valid), best_valid[0]);
        check_value("right_rho", int'(right_rho), best_rho[1]);
        check_value("right_theta", int'(right_theta), best_theta[1]);
        check_value("right_votes", int'(right_votes), best_votes[1]);
        check_value("right_valid", int'(right_valid), best_valid[1]);
    endtask

    task automatic check_reset_values();
        int errors_before;
        int value;
        errors_before = error_count;
        read_register(hough_pkg::mask_threshold_address, value);
        check_value("mask_threshold after reset", value, 8'h0F);
        read_register(hough_pkg::min_votes_address, value);
        check_value("min_votes after reset", value, 4);
        read_register(hough_pkg::control_address, value);
        check_value("busy after reset", value, 0);
        check_value("done after reset", int'(done), 0);
        for (int s = 0; s < 2; s++) begin
            best_votes[s] = 0;
            best_rho[s] = 0;
            best_theta[s] = 0;
            best_valid[s] = 0;
        end
        compare_results();
        report_test("reset_values", errors_before);
    endtask

    task automatic run_test(input int index);
        int errors_before;
        int value;
        int cycles;
        int extra_done;
        errors_before = error_count;
        fill_images(test_kind[index]);
        build_model(test_threshold[index], test_min_votes[index]);
        load_images();
        write_register(hough_pkg::mask_threshold_address, test_threshold[index]);
        write_register(hough_pkg::min_votes_address, test_min_votes[index]);
        read_register(hough_pkg::min_votes_address, value);
        check_value("min_votes readback", value, test_min_votes[index]);
        write_register(hough_pkg::control_address, 1);
        read_register(hough_pkg::control_address, value);
        check_value("busy during run", value, 1);
        // A second start in the middle of the run has to be dropped
        write_register(hough_pkg::control_address, 1);
        cycles = 0;
        while (done !== 1'b1 && cycles < run_cycles) begin
            @(negedge clock);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("Test %0s: done never came within %0d cycles", test_name[index], cycles);
            error_count++;
        end
        compare_results();
        extra_done = 0;
        repeat (scan_cycles) begin
            @(negedge clock);
            if (done === 1'b1) begin
                extra_done++;
            end
        end
        check_value("extra done pulses", extra_done, 0);
        read_register(hough_pkg::control_address, value);
        check_value("busy after done", value, 0);
        report_test(test_name[index], errors_before);
    endtask

    initial begin
        edge_write <= 1'b0;
        mask_write <= 1'b0;
        pixel_address <= '0;
        pixel_data <= '0;
        config_write <= 1'b0;
        config_address <= '0;
        config_data <= '0;
        wait (reset === 1'b0);
        check_reset_values();
        for (int i = 0; i < test_total; i++) begin
            run_test(i);
        end
        $display("Summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
            test_total + 1, failed_tests, error_count, UUT.protocol_checker.assertion_failures);
        if (error_count == 0 && UUT.protocol_checker.assertion_failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- src.f
logic/hough_pkg.sv
logic/image_bram.sv
logic/hough_config.sv
logic/hough_accumulator.sv
logic/lane_select.sv
logic/lane_hough_top.sv
verification/clock_gen.sv
verification/lane_hough_chk.sv
verification/lane_hough_tb.sv

//--- Makefile
# Verilator build and run of the Hough lane finder testbench

VERILATOR ?= verilator
TOP ?= lane_hough_tb
FILE_LIST ?= src.f
BUILD_DIR ?= build
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
SIM_FLAGS ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q -x -F '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
